//--- wb_settings.svh
/* Writeback stage settings */

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Data and address width of the data bus
`define WORD_WIDTH 32

// One enable per byte lane
`define BE_WIDTH 4

// Testbench limits, in clock cycles
`define TB_OP_TIMEOUT 64
`define TB_SIM_TIMEOUT 20000

`endif

//--- riscv_defines.sv
/* Load/store types and encodings */

`include "wb_settings.svh"

package riscv_defines;

	////////////////////////////////////////////////////////////
	// Control encodings from the previous stage
	////////////////////////////////////////////////////////////

	// Bit 2 marks unsigned for byte and half
	typedef enum logic [2:0] {
		LOAD_NONE = 3'b000,
		LOAD_LB   = 3'b001,
		LOAD_LH   = 3'b010,
		LOAD_LW   = 3'b100,
		LOAD_LBU  = 3'b101,
		LOAD_LHU  = 3'b110
	} load_type_e;

	typedef enum logic [1:0] {
		STORE_NONE = 2'b00,
		STORE_SB   = 2'b01,
		STORE_SH   = 2'b10,
		STORE_SW   = 2'b11
	} store_type_e;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} access_size_e;

	////////////////////////////////////////////////////////////
	// Data word and access request
	////////////////////////////////////////////////////////////

	// One bus word, whole or split into byte lanes
	typedef union packed {
		logic [`WORD_WIDTH-1:0]       word;
		logic [`BE_WIDTH-1:0][7:0]    lane;
	} mem_word_u;

	typedef struct packed {
		logic                    valid;
		logic                    write;
		access_size_e            size;
		logic                    sign_ext;
		logic                    misaligned;
		logic [`WORD_WIDTH-1:0]  addr;      // Word aligned
		logic [1:0]              offset;    // Byte inside the word
		logic [`BE_WIDTH-1:0]    be;
		mem_word_u               wdata;     // Already in its lanes
	} lsu_req_t;

endpackage

//--- lsu_ctrl_decode.sv
/* Load/store request decode */

`timescale 1ns/1ns
`include "wb_settings.svh"

module lsu_ctrl_decode (
	input  riscv_defines::load_type_e  load_type_i,
	input  riscv_defines::store_type_e store_type_i,
	input  logic [`WORD_WIDTH-1:0]     addr_i,
	input  logic [`WORD_WIDTH-1:0]     store_data_i,
	output riscv_defines::lsu_req_t    req_o
);
	import riscv_defines::*;

	logic         load_flag;
	logic         store_flag;
	access_size_e size;
	logic         sign_ext;
	logic [1:0]   offset;
	logic         misaligned;
	logic [`BE_WIDTH-1:0] be;
	mem_word_u    src;
	mem_word_u    lanes;

	assign load_flag  = (load_type_i != LOAD_NONE);
	assign store_flag = (store_type_i != STORE_NONE);
	assign offset     = addr_i[1:0];
	assign src        = store_data_i;

	// Size and signedness, a load wins over a store
	always_comb begin
		size     = SIZE_WORD;
		sign_ext = 1'b0;
		if (load_flag) begin
			case (load_type_i)
				LOAD_LB:  begin
					size     = SIZE_BYTE;
					sign_ext = 1'b1;
				end
				LOAD_LH:  begin
					size     = SIZE_HALF;
					sign_ext = 1'b1;
				end
				LOAD_LBU: size = SIZE_BYTE;
				LOAD_LHU: size = SIZE_HALF;
				default:  size = SIZE_WORD;
			endcase
		end else if (store_flag) begin
			case (store_type_i)
				STORE_SB: size = SIZE_BYTE;
				STORE_SH: size = SIZE_HALF;
				default:  size = SIZE_WORD;
			endcase
		end
	end

	// Halfword needs even address, word needs multiple of four
	always_comb begin
		case (size)
			SIZE_HALF: misaligned = offset[0];
			SIZE_WORD: misaligned = |offset;
			default:   misaligned = 1'b0;
		endcase
	end

	// Byte enables and lane placement of the store data
	always_comb begin
		be         = '0;
		lanes.word = '0;
		case (size)
			SIZE_BYTE: begin
				be[offset]        = 1'b1;
				lanes.lane[offset] = src.lane[0];
			end
			SIZE_HALF: begin
				// Upper or lower half, odd offsets are flagged above
				be[{offset[1], 1'b0}]         = 1'b1;
				be[{offset[1], 1'b1}]         = 1'b1;
				lanes.lane[{offset[1], 1'b0}] = src.lane[0];
				lanes.lane[{offset[1], 1'b1}] = src.lane[1];
			end
			default: begin
				be    = '1;
				lanes = src;
			end
		endcase
	end

	assign req_o.valid      = load_flag | store_flag;
	assign req_o.write      = store_flag & ~load_flag;
	assign req_o.size       = size;
	assign req_o.sign_ext   = sign_ext;
	assign req_o.misaligned = misaligned & (load_flag | store_flag);
	assign req_o.addr       = {addr_i[`WORD_WIDTH-1:2], 2'b00};
	assign req_o.offset     = offset;
	assign req_o.be         = be;
	assign req_o.wdata      = lanes;

endmodule

//--- lsu_lite.sv
/* Load/store bus sequencer */

`timescale 1ns/1ns
`include "wb_settings.svh"

module lsu_lite (
	input  logic                        clk,
	input  logic                        reset_i,
	input  riscv_defines::lsu_req_t     req_i,

	// Data bus
	output logic                        data_req_o,
	output logic [`WORD_WIDTH-1:0]      data_addr_o,
	output logic                        data_we_o,
	output logic [`BE_WIDTH-1:0]        data_be_o,
	output logic [`WORD_WIDTH-1:0]      data_wdata_o,
	input  logic [`WORD_WIDTH-1:0]      data_rdata_i,
	input  logic                        data_rvalid_i,
	input  logic                        data_gnt_i,

	// Captured load toward the extension
	output logic [`WORD_WIDTH-1:0]      rdata_o,
	output riscv_defines::access_size_e size_o,
	output logic                        signed_o,
	output logic [1:0]                  offset_o,

	// Pipeline strobes
	output logic                        stall_o,
	output logic                        wb_valid_o,
	output logic                        misalign_o
);
	import riscv_defines::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_WAIT_RESP
	} lsu_state_e;

	lsu_state_e             state_q;
	lsu_state_e             state_d;
	lsu_req_t               req_q;
	logic [`WORD_WIDTH-1:0] rdata_q;
	logic                   wb_valid_q;
	logic                   misalign_q;
	logic                   accept;
	logic                   start;
	logic                   resp_done;

	////////////////////////////////////////////////////////////
	// Request acceptance
	////////////////////////////////////////////////////////////

	// The cycle after a pulse still shows the old request,
	// the pipeline only advances at its end
	assign accept    = (state_q == ST_IDLE) && !wb_valid_q && !misalign_q;
	assign start     = accept && req_i.valid && !req_i.misaligned;
	assign resp_done = (state_q == ST_WAIT_RESP) && data_rvalid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (start) begin
					state_d = ST_REQUEST;
				end
			end
			// Hold the bus until granted
			ST_REQUEST: begin
				if (data_gnt_i) begin
					state_d = ST_WAIT_RESP;
				end
			end
			// Stores also get an rvalid
			ST_WAIT_RESP: begin
				if (data_rvalid_i) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q    <= ST_IDLE;
			wb_valid_q <= 1'b0;
			misalign_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			wb_valid_q <= resp_done;
			misalign_q <= accept && req_i.valid && req_i.misaligned;
		end
	end

	// Request snapshot and read data
	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= req_i;
		end
		if (resp_done) begin
			rdata_q <= data_rdata_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Registered through the state, stable until grant
	assign data_req_o   = (state_q == ST_REQUEST);
	assign data_addr_o  = req_q.addr;
	assign data_we_o    = req_q.write;
	assign data_be_o    = req_q.be;
	assign data_wdata_o = req_q.wdata.word;

	assign rdata_o  = rdata_q;
	assign size_o   = req_q.size;
	assign signed_o = req_q.sign_ext;
	assign offset_o = req_q.offset;

	// High on detection and through the whole transfer
	assign stall_o    = (state_q != ST_IDLE) || (accept && req_i.valid);
	assign wb_valid_o = wb_valid_q;
	assign misalign_o = misalign_q;

endmodule

//--- load_extend.sv
/* Load extension and writeback select */

`timescale 1ns/1ns
`include "wb_settings.svh"

module load_extend (
	input  logic [`WORD_WIDTH-1:0]      rdata_i,
	input  riscv_defines::access_size_e size_i,
	input  logic                        signed_i,
	input  logic [1:0]                  offset_i,
	input  logic                        wb_valid_i,
	input  logic [`WORD_WIDTH-1:0]      wb_data_i,
	output logic [`WORD_WIDTH-1:0]      reg_wdata_o
);
	import riscv_defines::*;

	mem_word_u              rword;
	logic [7:0]             sel_byte;
	logic [15:0]            sel_half;
	logic                   fill;
	logic [`WORD_WIDTH-1:0] load_data;

	assign rword = rdata_i;

	// Lane pick is the shift down by the byte offset
	assign sel_byte = rword.lane[offset_i];
	assign sel_half = {rword.lane[{offset_i[1], 1'b1}], rword.lane[{offset_i[1], 1'b0}]};

	////////////////////////////////////////////////////////////
	// Sign or zero extension
	////////////////////////////////////////////////////////////

	always_comb begin
		fill = 1'b0;
		case (size_i)
			SIZE_BYTE: begin
				fill      = signed_i & sel_byte[7];
				load_data = {{(`WORD_WIDTH-8){fill}}, sel_byte};
			end
			SIZE_HALF: begin
				fill      = signed_i & sel_half[15];
				load_data = {{(`WORD_WIDTH-16){fill}}, sel_half};
			end
			// Full word needs no extension
			default: load_data = rword.word;
		endcase
	end

	// ALU result passes through outside the writeback pulse
	assign reg_wdata_o = wb_valid_i ? load_data : wb_data_i;

endmodule

//--- wb_stage.sv
/* Writeback stage with LSU */

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_stage (
	input  logic                        clk,
	input  logic                        reset_i,

	// Data bus
	output logic                        data_req_o,
	output logic [`WORD_WIDTH-1:0]      data_addr_o,
	output logic                        data_we_o,
	output logic [`BE_WIDTH-1:0]        data_be_o,
	output logic [`WORD_WIDTH-1:0]      data_wdata_o,
	input  logic [`WORD_WIDTH-1:0]      data_rdata_i,
	input  logic                        data_rvalid_i,
	input  logic                        data_gnt_i,

	// Datapath from the previous stage
	input  riscv_defines::load_type_e   load_type_i,
	input  riscv_defines::store_type_e  store_type_i,
	input  logic [`WORD_WIDTH-1:0]      wb_data_i,
	input  logic [`WORD_WIDTH-1:0]      store_data_i,

	// Register write and pipeline control
	output logic [`WORD_WIDTH-1:0]      reg_wdata_o,
	output logic                        stall_o,
	output logic                        wb_valid_o,
	output logic                        misalign_o
);
	import riscv_defines::*;

	lsu_req_t               lsu_req;
	logic [`WORD_WIDTH-1:0] lsu_rdata;
	access_size_e           lsu_size;
	logic                   lsu_signed;
	logic [1:0]             lsu_offset;

	// Address or ALU result doubles as the access address
	lsu_ctrl_decode u_decode (
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.addr_i       (wb_data_i),
		.store_data_i (store_data_i),
		.req_o        (lsu_req)
	);

	lsu_lite u_lsu (
		.clk           (clk),
		.reset_i       (reset_i),
		.req_i         (lsu_req),
		.data_req_o    (data_req_o),
		.data_addr_o   (data_addr_o),
		.data_we_o     (data_we_o),
		.data_be_o     (data_be_o),
		.data_wdata_o  (data_wdata_o),
		.data_rdata_i  (data_rdata_i),
		.data_rvalid_i (data_rvalid_i),
		.data_gnt_i    (data_gnt_i),
		.rdata_o       (lsu_rdata),
		.size_o        (lsu_size),
		.signed_o      (lsu_signed),
		.offset_o      (lsu_offset),
		.stall_o       (stall_o),
		.wb_valid_o    (wb_valid_o),
		.misalign_o    (misalign_o)
	);

	load_extend u_extend (
		.rdata_i     (lsu_rdata),
		.size_i      (lsu_size),
		.signed_i    (lsu_signed),
		.offset_i    (lsu_offset),
		.wb_valid_i  (wb_valid_o),
		.wb_data_i   (wb_data_i),
		.reg_wdata_o (reg_wdata_o)
	);

endmodule

//--- wb_stage_checker.sv
/* Data bus protocol checker */

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_stage_checker (
	input logic                   clk,
	input logic                   reset_i,
	input logic                   req_i,
	input logic [`WORD_WIDTH-1:0] addr_i,
	input logic                   we_i,
	input logic [`BE_WIDTH-1:0]   be_i,
	input logic [`WORD_WIDTH-1:0] wdata_i,
	input logic                   gnt_i,
	input logic                   rvalid_i,
	input logic                   stall_i,
	input logic                   wb_valid_i,
	input logic                   misalign_i
);
	// Sticky error flag for each group of properties
	logic stable_err = 1'b0;
	logic overlap_err = 1'b0;
	logic pulse_err = 1'b0;
	logic follow_err = 1'b0;
	logic stall_err = 1'b0;
	logic any_error;

	assign any_error = stable_err | overlap_err | pulse_err | follow_err | stall_err;

	////////////////////////////////////////////////////////////
	// Bus request
	////////////////////////////////////////////////////////////

	// Address, enables and data frozen until the grant
	assert property (@(posedge clk) disable iff (reset_i)
		req_i && !gnt_i |=> req_i && $stable(addr_i) && $stable(we_i)
			&& $stable(be_i) && $stable(wdata_i))
	else begin
		$error("Bus request changed or dropped before its grant");
		stable_err = 1'b1;
	end

	// A misaligned access never reaches the bus
	assert property (@(posedge clk) disable iff (reset_i) !(misalign_i && req_i))
	else begin
		$error("Misalignment pulse together with a bus request");
		overlap_err = 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Pipeline strobes
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset_i) wb_valid_i |=> !wb_valid_i)
	else begin
		$error("Writeback valid longer than one cycle");
		pulse_err = 1'b1;
	end

	// Writeback exactly one cycle after the response
	assert property (@(posedge clk) disable iff (reset_i) rvalid_i |=> wb_valid_i)
	else begin
		$error("Writeback valid missing one cycle after rvalid");
		follow_err = 1'b1;
	end

	assert property (@(posedge clk) disable iff (reset_i) wb_valid_i |-> $past(rvalid_i))
	else begin
		$error("Writeback valid without rvalid one cycle before");
		follow_err = 1'b1;
	end

	// Stall covers the request and the response
	assert property (@(posedge clk) disable iff (reset_i) req_i || rvalid_i |-> stall_i)
	else begin
		$error("Stall low while a transfer is in flight");
		stall_err = 1'b1;
	end

endmodule

//--- tb_wb_stage.sv
/* Writeback stage testbench */

`timescale 1ns/1ns
`include "wb_settings.svh"

module tb_wb_stage;
	import riscv_defines::*;

	logic clk = 1'b0;
	logic reset_i;
	logic data_req_o, data_we_o;
	logic [`WORD_WIDTH-1:0] data_addr_o, data_wdata_o;
	logic [`BE_WIDTH-1:0] data_be_o;
	logic [`WORD_WIDTH-1:0] data_rdata_i = '0;
	logic data_rvalid_i = 1'b0;
	logic data_gnt_i = 1'b0;
	load_type_e load_type_i;
	store_type_e store_type_i;
	logic [`WORD_WIDTH-1:0] wb_data_i, store_data_i, reg_wdata_o;
	logic stall_o, wb_valid_o, misalign_o;

	// Separate streams for stimulus and bus latency
	integer seed = 32'h816b;
	integer lat_seed = 32'h816b;
	string test_name = "init";
	logic [7:0] shadow [0:255];
	store_type_e cur_store = STORE_NONE;
	logic [`WORD_WIDTH-1:0] cur_addr = '0;
	logic [`WORD_WIDTH-1:0] cur_sdata = '0;

	wb_stage UUT (.*);

	bind wb_stage wb_stage_checker u_checker (
		.clk(clk), .reset_i(reset_i), .req_i(data_req_o), .addr_i(data_addr_o),
		.we_i(data_we_o), .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_i(data_gnt_i),
		.rvalid_i(data_rvalid_i), .stall_i(stall_o), .wb_valid_i(wb_valid_o),
		.misalign_i(misalign_o)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Failure reporting and small helpers
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_failure(input string reason);
		$display("%s (test %s)", reason, test_name);
		abort_run();
	endtask

	task automatic mismatch(input logic [31:0] expected, input logic [31:0] actual);
		$display("MISMATCH %s expected %08h actual %08h", test_name, expected, actual);
		abort_run();
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// Little endian read of the shadow memory by load type
	function automatic logic [31:0] expected_load(input load_type_e lt, input logic [31:0] addr);
		logic [7:0] b0, b1, b2, b3;
		b0 = shadow[addr[7:0]];
		b1 = shadow[addr[7:0] + 8'd1];
		b2 = shadow[addr[7:0] + 8'd2];
		b3 = shadow[addr[7:0] + 8'd3];
		case (lt)
			LOAD_LB:  return {{24{b0[7]}}, b0};
			LOAD_LBU: return {24'd0, b0};
			LOAD_LH:  return {{16{b1[7]}}, b1, b0};
			LOAD_LHU: return {16'd0, b1, b0};
			default:  return {b3, b2, b1, b0};
		endcase
	endfunction

	function automatic logic [3:0] expected_be(input store_type_e st, input logic [1:0] off);
		case (st)
			STORE_SB: return 4'b0001 << off;
			STORE_SH: return 4'b0011 << off;
			default:  return 4'b1111;
		endcase
	endfunction

	// Store data shifted up into its lanes with zeros elsewhere
	function automatic logic [31:0] placed_data(input store_type_e st, input logic [1:0] off,
			input logic [31:0] sdata);
		case (st)
			STORE_SB: return {24'd0, sdata[7:0]} << {off, 3'b000};
			STORE_SH: return {16'd0, sdata[15:0]} << {off, 3'b000};
			default:  return sdata;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Memory model with random grant and response delay
	////////////////////////////////////////////////////////////

	task automatic check_bus_request();
		assert (data_addr_o == {cur_addr[31:2], 2'b00})
			else mismatch({cur_addr[31:2], 2'b00}, data_addr_o);
		if (cur_store != STORE_NONE) begin
			assert (data_we_o) else report_failure("Store issued without write enable");
			assert (data_be_o == expected_be(cur_store, cur_addr[1:0]))
				else mismatch(32'(expected_be(cur_store, cur_addr[1:0])), 32'(data_be_o));
			assert (data_wdata_o == placed_data(cur_store, cur_addr[1:0], cur_sdata))
				else mismatch(placed_data(cur_store, cur_addr[1:0], cur_sdata), data_wdata_o);
		end else begin
			assert (!data_we_o) else report_failure("Load issued with write enable");
		end
	endtask

	always begin : memory_model
		int unsigned delay;
		logic [5:0] word_idx;
		step_cycle();
		if (data_req_o) begin
			delay = $unsigned($random(lat_seed)) % 4;
			repeat (delay) step_cycle();
			check_bus_request();
			word_idx = data_addr_o[7:2];
			for (int i = 0; i < 4; i++) begin
				if (data_we_o && data_be_o[i]) begin
					shadow[{word_idx, 2'(i)}] = data_wdata_o[8*i +: 8];
				end
			end
			data_gnt_i = 1'b1;
			step_cycle();
			data_gnt_i = 1'b0;
			// rvalid 1 to 3 cycles after the grant
			delay = $unsigned($random(lat_seed)) % 3;
			repeat (delay) step_cycle();
			data_rdata_i = {shadow[{word_idx, 2'd3}], shadow[{word_idx, 2'd2}],
				shadow[{word_idx, 2'd1}], shadow[{word_idx, 2'd0}]};
			data_rvalid_i = 1'b1;
			step_cycle();
			data_rvalid_i = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// One memory operation from issue to writeback
	////////////////////////////////////////////////////////////

	task automatic run_op(input string name, input load_type_e lt, input store_type_e st,
			input logic [31:0] addr, input logic [31:0] sdata, input logic bad_align);
		int cycles;
		logic [31:0] exp_data;
		cycles = 0;
		test_name = name;
		exp_data = expected_load(lt, addr);
		cur_store = st;
		cur_addr = addr;
		cur_sdata = sdata;
		load_type_i = lt;
		store_type_i = st;
		wb_data_i = addr;
		store_data_i = sdata;
		#1;
		assert (stall_o) else report_failure("Stall not raised for a memory operation");
		while (!wb_valid_o && !misalign_o) begin
			assert (stall_o) else report_failure("Stall dropped before the writeback");
			if (bad_align) begin
				assert (!data_req_o)
					else report_failure("Bus request raised for a misaligned access");
			end
			if (cycles >= `TB_OP_TIMEOUT) begin
				report_failure("No writeback or misalignment pulse before the timeout");
			end
			step_cycle();
			cycles++;
		end
		if (bad_align) begin
			assert (misalign_o && !wb_valid_o && !stall_o)
				else report_failure("Misaligned access not flagged as expected");
		end else begin
			assert (wb_valid_o && !misalign_o && !stall_o)
				else report_failure("Writeback pulse missing or stall still high");
			if (lt != LOAD_NONE) begin
				assert (reg_wdata_o == exp_data) else mismatch(exp_data, reg_wdata_o);
			end
		end
		// Pipeline moves on at the end of the pulse cycle
		step_cycle();
		if (bad_align) begin
			assert (!data_req_o)
				else report_failure("Bus request raised after the misalignment pulse");
		end
		load_type_i = LOAD_NONE;
		store_type_i = STORE_NONE;
	endtask

	initial begin : watchdog
		for (int n = 0; n < `TB_SIM_TIMEOUT; n++) begin
			@(posedge clk);
		end
		report_failure("Simulation did not finish before the global timeout");
	end

	always @(posedge clk) begin
		if (UUT.u_checker.any_error) begin
			report_failure("Protocol assertion failed in the checker");
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		int unsigned pick;
		logic [31:0] addr;
		logic [31:0] data;
		// Fill pattern from the full byte address
		for (int a = 0; a < 256; a++) begin
			shadow[a] = 8'(a * 37) ^ 8'h5a;
		end
		reset_i = 1'b1;
		load_type_i = LOAD_NONE;
		store_type_i = STORE_NONE;
		wb_data_i = '0;
		store_data_i = '0;
		repeat (5) @(posedge clk);
		#1;
		reset_i = 1'b0;
		test_name = "reset";
		assert (!data_req_o && !stall_o && !wb_valid_o && !misalign_o)
			else report_failure("Outputs not low after reset");

		// ALU result straight through
		test_name = "pass-through";
		for (int i = 0; i < 8; i++) begin
			wb_data_i = $random(seed);
			#1;
			assert (reg_wdata_o == wb_data_i) else mismatch(wb_data_i, reg_wdata_o);
			assert (!data_req_o && !stall_o && !wb_valid_o)
				else report_failure("Strobes active without a memory operation");
			step_cycle();
		end

		// Stores at every legal offset
		for (int i = 0; i < 4; i++) begin
			run_op($sformatf("SB off %0d", i), LOAD_NONE, STORE_SB, 32'h40 + i, $random(seed), 0);
		end
		run_op("SH off 0", LOAD_NONE, STORE_SH, 32'h44, $random(seed), 1'b0);
		run_op("SH off 2", LOAD_NONE, STORE_SH, 32'h46, $random(seed), 1'b0);
		run_op("SW off 0", LOAD_NONE, STORE_SW, 32'h48, $random(seed), 1'b0);

		// Read back with both extensions
		for (int i = 0; i < 4; i++) begin
			run_op($sformatf("LB off %0d", i), LOAD_LB, STORE_NONE, 32'h40 + i, '0, 1'b0);
			run_op($sformatf("LBU off %0d", i), LOAD_LBU, STORE_NONE, 32'h40 + i, '0, 1'b0);
		end
		for (int i = 0; i < 4; i += 2) begin
			run_op($sformatf("LH off %0d", i), LOAD_LH, STORE_NONE, 32'h44 + i, '0, 1'b0);
			run_op($sformatf("LHU off %0d", i), LOAD_LHU, STORE_NONE, 32'h44 + i, '0, 1'b0);
		end
		run_op("LW word 0x40", LOAD_LW, STORE_NONE, 32'h40, '0, 1'b0);
		run_op("LW word 0x48", LOAD_LW, STORE_NONE, 32'h48, '0, 1'b0);

		// Misaligned halfword and word accesses
		for (int i = 1; i < 4; i++) begin
			run_op($sformatf("LW misaligned %0d", i), LOAD_LW, STORE_NONE, 32'h50 + i, '0, 1);
			run_op($sformatf("SW misaligned %0d", i), LOAD_NONE, STORE_SW, 32'h50 + i, '1, 1);
		end
		for (int i = 1; i < 4; i += 2) begin
			run_op($sformatf("LH misaligned %0d", i), LOAD_LH, STORE_NONE, 32'h54 + i, '0, 1);
			run_op($sformatf("LHU misaligned %0d", i), LOAD_LHU, STORE_NONE, 32'h54 + i, '0, 1);
			run_op($sformatf("SH misaligned %0d", i), LOAD_NONE, STORE_SH, 32'h54 + i, '1, 1);
		end

		// Random mix over the whole shadow memory
		for (int i = 0; i < 48; i++) begin
			pick = $unsigned($random(seed)) % 8;
			addr = {24'd0, 8'($random(seed))};
			data = $random(seed);
			case (pick)
				0: run_op("random SB", LOAD_NONE, STORE_SB, addr, data, 1'b0);
				1: run_op("random SH", LOAD_NONE, STORE_SH, {addr[31:1], 1'b0}, data, 1'b0);
				2: run_op("random SW", LOAD_NONE, STORE_SW, {addr[31:2], 2'b00}, data, 1'b0);
				3: run_op("random LB", LOAD_LB, STORE_NONE, addr, '0, 1'b0);
				4: run_op("random LBU", LOAD_LBU, STORE_NONE, addr, '0, 1'b0);
				5: run_op("random LH", LOAD_LH, STORE_NONE, {addr[31:1], 1'b0}, '0, 1'b0);
				6: run_op("random LHU", LOAD_LHU, STORE_NONE, {addr[31:1], 1'b0}, '0, 1'b0);
				default: run_op("random LW", LOAD_LW, STORE_NONE, {addr[31:2], 2'b00}, '0, 1'b0);
			endcase
		end

		step_cycle();
		if (UUT.u_checker.any_error) begin
			report_failure("Protocol assertion failed in the checker");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- filelist.f
+incdir+.
riscv_defines.sv
lsu_ctrl_decode.sv
lsu_lite.sv
load_extend.sv
wb_stage.sv
wb_stage_checker.sv
tb_wb_stage.sv

//--- Makefile
# Verilator build and run of the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) wb_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_FLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
